// File: all.f
+incdir+design
design/mem_stage_pkg.sv
design/ex_mem_reg.sv
design/store_align.sv
design/data_ram.sv
design/mem_wb_reg.sv
design/writeback_select.sv
design/mem_stage_top.sv
dv/mem_stage_tb.sv

// File: Makefile
TOP := mem_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/mem_stage_tb.sv
module mem_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_stage_pkg::*;

    // 64-word window with a zero low byte in the base
    localparam word_t WIN_BASE  = 32'h0000_0400;
    localparam int    ALU_OPS   = 24;
    localparam int    FILL_OPS  = 64;
    localparam int    PAIR_OPS  = 32;
    localparam int    LANE_OPS  = 160;
    localparam int    MIX_OPS   = 300;
    localparam int    TOTAL_OPS = ALU_OPS + FILL_OPS + PAIR_OPS + LANE_OPS + MIX_OPS;

    logic      CLK = 1'b0;
    logic      rst_n;
    logic      stall;
    ex_mem_t   ex_in;
    reg_addr_t rd_addr;
    word_t     rd_data;
    logic      rd_we;

    logic [31:0] lfsr = 32'h9204_7da2;
    logic [7:0]  ref_mem [256];
    ex_mem_t     ref_q;
    logic        exp_we;
    reg_addr_t   exp_addr;
    word_t       exp_data;
    int          err_count = 0;
    int          op_count = 0;
    int          test_errs;
    int          test_ops;

    mem_stage_top dut_i (.*);

    always #5 CLK = ~CLK;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference memory as little-endian bytes of the window
    //////////////////////////////////////////////////////////////////////

    function automatic void write_ref(input store_op_t op, input word_t addr, input word_t data);
        logic [7:0] a;
        a = addr[7:0];
        case (op)
            STORE_B: ref_mem[a] = data[7:0];
            STORE_H:
            begin
                ref_mem[{a[7:1], 1'b0}] = data[7:0];
                ref_mem[{a[7:1], 1'b1}] = data[15:8];
            end
            STORE_W:
            begin
                for (int i = 0; i < 4; i++)
                begin
                    ref_mem[{a[7:2], 2'(i)}] = data[8*i +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    function automatic word_t read_ref(input load_op_t op, input word_t addr);
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[7:0];
        b = ref_mem[a];
        h = {ref_mem[{a[7:1], 1'b1}], ref_mem[{a[7:1], 1'b0}]};
        case (op)
            LOAD_B:  return {{24{b[7]}}, b};
            LOAD_BU: return {24'h0, b};
            LOAD_H:  return {{16{h[15]}}, h};
            LOAD_HU: return {16'h0, h};
            default: return {ref_mem[{a[7:2], 2'd3}], ref_mem[{a[7:2], 2'd2}],
                             ref_mem[{a[7:2], 2'd1}], ref_mem[{a[7:2], 2'd0}]};
        endcase
    endfunction

    // Op in flight moves on only at unstalled edges
    always @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ref_q  <= '0;
            exp_we <= 1'b0;
        end
        else if (!stall)
        begin
            write_ref(ref_q.store_op, ref_q.alu_result, ref_q.store_data);
            exp_we   <= ref_q.rd_we;
            exp_addr <= ref_q.rd_addr;
            exp_data <= ref_q.wb_sel ? read_ref(ref_q.load_op, ref_q.alu_result)
                                     : ref_q.alu_result;
            ref_q    <= ex_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output checks
    //////////////////////////////////////////////////////////////////////

    a_rd_we: assert property (@(posedge CLK) disable iff (!rst_n) rd_we === exp_we)
        else
        begin
            err_count++;
            $display("error: rd_we 0x%0h, expected 0x%0h", $sampled(rd_we), $sampled(exp_we));
        end

    a_rd_addr: assert property (@(posedge CLK) disable iff (!rst_n)
        exp_we |-> rd_addr === exp_addr)
        else
        begin
            err_count++;
            $display("error: rd_addr 0x%02h, expected 0x%02h", $sampled(rd_addr),
                     $sampled(exp_addr));
        end

    a_rd_data: assert property (@(posedge CLK) disable iff (!rst_n)
        exp_we |-> rd_data === exp_data)
        else
        begin
            err_count++;
            $display("error: rd_data 0x%08h, expected 0x%08h", $sampled(rd_data),
                     $sampled(exp_data));
        end

    // Nothing moves on a stalled edge
    a_stall_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        $past(stall) && rd_we |-> $stable({rd_we, rd_addr, rd_data}))
        else
        begin
            err_count++;
            $display("error: outputs changed under stall, rd_we 0x%0h rd_addr 0x%02h",
                     $sampled(rd_we), $sampled(rd_addr));
            $display("error: outputs changed under stall, rd_data 0x%08h",
                     $sampled(rd_data));
        end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic ex_mem_t alu_item(input logic we);
        ex_mem_t it;
        it            = '0;
        it.rd_addr    = 5'(rand_bits(5));
        it.alu_result = rand_bits(32);
        it.rd_we      = we;
        return it;
    endfunction

    function automatic ex_mem_t store_item(input store_op_t op, input word_t addr,
                                           input word_t data);
        ex_mem_t it;
        it            = '0;
        it.alu_result = addr;
        it.store_op   = op;
        it.store_data = data;
        return it;
    endfunction

    function automatic ex_mem_t load_item(input load_op_t op, input word_t addr);
        ex_mem_t it;
        it            = '0;
        it.rd_addr    = 5'(rand_bits(5));
        it.alu_result = addr;
        it.load_op    = op;
        it.wb_sel     = 1'b1;
        it.rd_we      = 1'b1;
        return it;
    endfunction

    function automatic ex_mem_t random_item();
        word_t       addr;
        word_t       data;
        logic [31:0] kind;
        store_op_t   so;
        addr = WIN_BASE | rand_bits(8);
        kind = rand_bits(2);
        data = rand_bits(32);
        so   = 2'(rand_bits(2));
        if (kind == 0)
            return alu_item(rand_bits(1) == 1);
        else if (kind == 1)
            return store_item((so == STORE_NONE) ? STORE_W : so, addr, data);
        else
            return load_item(3'(rand_bits(3) % 5 + 1), addr);
    endfunction

    // Held until an unstalled edge takes it
    task automatic issue(input ex_mem_t item, input bit stalls);
        logic s;
        do
        begin
            s     = stalls && (rand_bits(2) == 0);
            ex_in = item;
            stall = s;
            @(posedge CLK);
            #1;
        end
        while (s);
        op_count++;
        test_ops++;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            ex_in = '0;
            stall = 1'b0;
            @(posedge CLK);
            #1;
        end
    endtask

    // Two edges to the outputs and one more for the check
    task automatic report_test(input int num, input string name);
        idle(3);
        $display("test %0d %s: %0d ops, %0d errors", num, name, test_ops,
                 err_count - test_errs);
        test_errs = err_count;
        test_ops  = 0;
    endtask

    initial
    begin
        word_t addr;
        rst_n     = 1'b0;
        stall     = 1'b0;
        ex_in     = '0;
        test_errs = 0;
        test_ops  = 0;
        repeat (5) @(posedge CLK);
        #1;
        rst_n = 1'b1;

        idle(8);
        report_test(1, "reset_idle");

        // Every fourth op has no write-back
        for (int i = 0; i < ALU_OPS; i++)
            issue(alu_item(i % 4 != 3), 1'b0);
        report_test(2, "alu_ops");

        // Whole window written first so no load sees an unwritten word
        for (int i = 0; i < FILL_OPS; i++)
            issue(store_item(STORE_W, WIN_BASE + 32'(4 * i), rand_bits(32)), 1'b0);
        for (int i = 0; i < PAIR_OPS / 4; i++)
        begin
            addr = WIN_BASE | (rand_bits(6) << 2);
            issue(store_item(STORE_W, addr, rand_bits(32)), 1'b0);
            issue(load_item(LOAD_W, addr), 1'b0);
            issue(store_item(STORE_W, addr, rand_bits(32)), 1'b0);
            idle(1);
            issue(load_item(LOAD_W, addr), 1'b0);
        end
        report_test(3, "word_store_load");

        // Negative byte in lane 1 and positive upper half
        for (int w = 0; w < LANE_OPS / 20; w++)
        begin
            addr = WIN_BASE | (rand_bits(6) << 2);
            issue(store_item(STORE_B, addr + 1, rand_bits(32) | 32'h80), 1'b0);
            issue(store_item(STORE_H, addr + 2, rand_bits(32) & 32'hFFFF_7FFF), 1'b0);
            issue(store_item(STORE_B, addr, rand_bits(32)), 1'b0);
            issue(load_item(LOAD_W, addr), 1'b0);
            for (int k = 0; k < 4; k++)
            begin
                issue(load_item(LOAD_B, addr + k), 1'b0);
                issue(load_item(LOAD_BU, addr + k), 1'b0);
                issue(load_item(LOAD_H, addr + k), 1'b0);
                issue(load_item(LOAD_HU, addr + k), 1'b0);
            end
        end
        report_test(4, "sub_word_lanes");

        for (int i = 0; i < MIX_OPS; i++)
            issue(random_item(), 1'b1);
        report_test(5, "stall_mix");

        $display("ops: %0d, errors: %0d", op_count, err_count);
        if (err_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #((TOTAL_OPS * 20 + 100) * 10);
        $display("timeout: run did not end after %0d ops", op_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: design/mem_stage_top.sv
`include "mem_stage_config.svh"

module mem_stage_top (
    input  logic                     CLK,
    input  logic                     rst_n,
    input  logic                     stall,
    input  mem_stage_pkg::ex_mem_t   ex_in,
    output mem_stage_pkg::reg_addr_t rd_addr,
    output mem_stage_pkg::word_t     rd_data,
    output logic                     rd_we
);

    import mem_stage_pkg::*;

    ex_mem_t                   ex_q;
    mem_wb_t                   wb_q;
    byte_en_t                  ram_be;
    word_t                     ram_wdata;
    word_t                     ram_rdata;
    logic [`DMEM_INDEX_W-1:0]  ram_index;
    logic                      ram_re;

    //////////////////////////////////////////////////////////////////////
    // Memory stage
    //////////////////////////////////////////////////////////////////////

    ex_mem_reg ex_mem_reg_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .stall (stall),
        .ex_in (ex_in),
        .ex_q  (ex_q)
    );

    store_align store_align_i (
        .store_op   (ex_q.store_op),
        .addr       (ex_q.alu_result),
        .store_data (ex_q.store_data),
        .be         (ram_be),
        .wdata      (ram_wdata),
        .index      (ram_index)
    );

    // Read only for loads
    assign ram_re = (ex_q.load_op != LOAD_NONE);

    data_ram data_ram_i (
        .CLK   (CLK),
        .stall (stall),
        .re    (ram_re),
        .be    (ram_be),
        .index (ram_index),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Write-back
    //////////////////////////////////////////////////////////////////////

    mem_wb_reg mem_wb_reg_i (
        .CLK   (CLK),
        .rst_n (rst_n),
        .stall (stall),
        .ex_q  (ex_q),
        .wb_q  (wb_q)
    );

    writeback_select writeback_select_i (
        .wb_q    (wb_q),
        .rdata   (ram_rdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_we   (rd_we)
    );

endmodule

// File: design/writeback_select.sv
module writeback_select (
    input  mem_stage_pkg::mem_wb_t   wb_q,
    input  mem_stage_pkg::word_t     rdata,
    output mem_stage_pkg::reg_addr_t rd_addr,
    output mem_stage_pkg::word_t     rd_data,
    output logic                     rd_we
);

    import mem_stage_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_data;

    //////////////////////////////////////////////////////////////////////
    // Lane extraction
    //////////////////////////////////////////////////////////////////////

    assign load_byte = rdata[{wb_q.byte_off, 3'b000} +: 8];

    // Halfword lane from offset bit 1 only
    assign load_half = wb_q.byte_off[1] ? rdata[31:16] : rdata[15:0];

    always_comb
    begin
        case (wb_q.load_op)
            LOAD_B:
            begin
                load_data = {{24{load_byte[7]}}, load_byte};
            end
            LOAD_H:
            begin
                load_data = {{16{load_half[15]}}, load_half};
            end
            LOAD_BU:
            begin
                load_data = {24'h000000, load_byte};
            end
            LOAD_HU:
            begin
                load_data = {16'h0000, load_half};
            end
            default:
            begin
                // LOAD_W and no load pass the word through
                load_data = rdata;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back mux
    //////////////////////////////////////////////////////////////////////

    assign rd_data = wb_q.wb_sel ? load_data : wb_q.alu_result;
    assign rd_addr = wb_q.rd_addr;
    assign rd_we   = wb_q.rd_we;

endmodule

// File: design/mem_wb_reg.sv
module mem_wb_reg (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   stall,
    input  mem_stage_pkg::ex_mem_t ex_q,
    output mem_stage_pkg::mem_wb_t wb_q
);

    import mem_stage_pkg::*;

    // Control fields
    logic      rd_we_q;
    load_op_t  load_op_q;

    // Payload
    reg_addr_t rd_addr_q;
    word_t     alu_result_q;
    byte_off_t byte_off_q;
    logic      wb_sel_q;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_we_q   <= 1'b0;
            load_op_q <= LOAD_NONE;
        end
        else if (!stall)
        begin
            rd_we_q   <= ex_q.rd_we;
            load_op_q <= ex_q.load_op;
        end
    end

    // Byte offset kept for lane extraction after the RAM read
    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            rd_addr_q    <= ex_q.rd_addr;
            alu_result_q <= ex_q.alu_result;
            byte_off_q   <= ex_q.alu_result[1:0];
            wb_sel_q     <= ex_q.wb_sel;
        end
    end

    assign wb_q = '{rd_addr: rd_addr_q, alu_result: alu_result_q, load_op: load_op_q,
                    byte_off: byte_off_q, wb_sel: wb_sel_q, rd_we: rd_we_q};

    // RAM data only valid when a load read it
    a_wb_sel_needs_load: assert property (@(posedge CLK) disable iff (!rst_n)
        !(wb_q.rd_we && wb_q.wb_sel && (wb_q.load_op == LOAD_NONE)))
        else $error("mem_wb_reg: wb_sel=%0h with load_op=%0h and rd_we=%0h",
                    wb_q.wb_sel, wb_q.load_op, wb_q.rd_we);

endmodule

// File: design/data_ram.sv
`include "mem_stage_config.svh"

module data_ram (
    input  logic                      CLK,
    input  logic                      stall,
    input  logic                      re,
    input  mem_stage_pkg::byte_en_t   be,
    input  logic [`DMEM_INDEX_W-1:0]  index,
    input  mem_stage_pkg::word_t      wdata,
    output mem_stage_pkg::word_t      rdata
);

    import mem_stage_pkg::*;

    // Word array, one enable per byte lane
    word_t mem [`DMEM_WORDS];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (be[lane])
                begin
                    mem[index][8*lane +: 8] <= wdata[8*lane +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Old word on a same-cycle write, last word kept otherwise
    always_ff @(posedge CLK)
    begin
        if (!stall && re)
        begin
            rdata <= mem[index];
        end
    end

endmodule

// File: design/store_align.sv
`include "mem_stage_config.svh"

module store_align (
    input  mem_stage_pkg::store_op_t  store_op,
    input  mem_stage_pkg::word_t      addr,
    input  mem_stage_pkg::word_t      store_data,
    output mem_stage_pkg::byte_en_t   be,
    output mem_stage_pkg::word_t      wdata,
    output logic [`DMEM_INDEX_W-1:0]  index
);

    import mem_stage_pkg::*;

    byte_off_t off;

    assign off = addr[1:0];

    //////////////////////////////////////////////////////////////////////
    // Lane replication and byte enables
    //////////////////////////////////////////////////////////////////////

    // Data goes to every lane, the enables pick the one that lands
    always_comb
    begin
        case (store_op)
            STORE_B:
            begin
                wdata = {4{store_data[7:0]}};
                be    = 4'b0001 << off;
            end
            STORE_H:
            begin
                wdata = {2{store_data[15:0]}};
                // Low bit of the offset is ignored
                if (off[1])
                begin
                    be = 4'b1100;
                end
                else
                begin
                    be = 4'b0011;
                end
            end
            STORE_W:
            begin
                wdata = store_data;
                be    = 4'b1111;
            end
            default:
            begin
                wdata = store_data;
                be    = 4'b0000;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Word index
    //////////////////////////////////////////////////////////////////////

    // Upper address bits wrap around the depth
    assign index = addr[`DMEM_BYTE_ADDR_W-1:2];

endmodule

// File: design/ex_mem_reg.sv
module ex_mem_reg (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   stall,
    input  mem_stage_pkg::ex_mem_t ex_in,
    output mem_stage_pkg::ex_mem_t ex_q
);

    import mem_stage_pkg::*;

    // Control fields
    logic      rd_we_q;
    load_op_t  load_op_q;
    store_op_t store_op_q;

    // Payload
    reg_addr_t rd_addr_q;
    word_t     alu_result_q;
    word_t     store_data_q;
    logic      wb_sel_q;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_we_q    <= 1'b0;
            load_op_q  <= LOAD_NONE;
            store_op_q <= STORE_NONE;
        end
        else if (!stall)
        begin
            rd_we_q    <= ex_in.rd_we;
            load_op_q  <= ex_in.load_op;
            store_op_q <= ex_in.store_op;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            rd_addr_q    <= ex_in.rd_addr;
            alu_result_q <= ex_in.alu_result;
            store_data_q <= ex_in.store_data;
            wb_sel_q     <= ex_in.wb_sel;
        end
    end

    assign ex_q = '{rd_addr: rd_addr_q, alu_result: alu_result_q, load_op: load_op_q,
                    store_op: store_op_q, store_data: store_data_q, wb_sel: wb_sel_q,
                    rd_we: rd_we_q};

    // RAM port is shared, one access kind per op
    a_no_load_and_store: assert property (@(posedge CLK) disable iff (!rst_n)
        !((ex_q.load_op != LOAD_NONE) && (ex_q.store_op != STORE_NONE)))
        else $error("ex_mem_reg: load_op=%0h and store_op=%0h both active",
                    ex_q.load_op, ex_q.store_op);

endmodule

// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

    //////////////////////////////////////////////////////////////////////
    // Basic vectors
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  load_op_t;
    typedef logic [1:0]  store_op_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  byte_off_t;

    // Load codes
    localparam load_op_t LOAD_NONE = 3'd0;
    localparam load_op_t LOAD_B    = 3'd1;
    localparam load_op_t LOAD_H    = 3'd2;
    localparam load_op_t LOAD_W    = 3'd3;
    localparam load_op_t LOAD_BU   = 3'd4;
    localparam load_op_t LOAD_HU   = 3'd5;

    // Store codes
    localparam store_op_t STORE_NONE = 2'd0;
    localparam store_op_t STORE_B    = 2'd1;
    localparam store_op_t STORE_H    = 2'd2;
    localparam store_op_t STORE_W    = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////////////////////////

    // Execute result entering the memory stage
    typedef struct packed {
        reg_addr_t rd_addr;
        word_t     alu_result;  // result, or address for memory ops
        load_op_t  load_op;
        store_op_t store_op;
        word_t     store_data;
        logic      wb_sel;      // 1 takes load data
        logic      rd_we;
    } ex_mem_t;

    // What write-back still needs
    typedef struct packed {
        reg_addr_t rd_addr;
        word_t     alu_result;
        load_op_t  load_op;
        byte_off_t byte_off;
        logic      wb_sel;
        logic      rd_we;
    } mem_wb_t;

endpackage

// File: design/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Data memory geometry
//////////////////////////////////////////////////////////////////////

// Depth in 32-bit words
`define DMEM_WORDS 1024

// Word index width, log2 of the depth
`define DMEM_INDEX_W 10

// Byte address bits that select a word
`define DMEM_BYTE_ADDR_W (`DMEM_INDEX_W + 2)

`endif
